/* verilog/fetch_pkg.sv */
package fetch_pkg;

    ////////////////////////////////////////
    // sizes and constants
    ////////////////////////////////////////
    localparam int          xlen           = 32;
    localparam logic [31:0] reset_pc       = 32'h0000_0000;
    // addi x0,x0,0
    localparam logic [31:0] nop_instr      = 32'h0000_0013;
    localparam int          bht_index_bits = 4;
    localparam int          bht_entries    = 16;

    ////////////////////////////////////////
    // opcodes and funct3
    ////////////////////////////////////////
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;

    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    ////////////////////////////////////////
    // instruction views
    ////////////////////////////////////////
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // same word, two field layouts
    typedef union packed {
        b_fmt_t b;
        j_fmt_t j;
    } instr_u;

    ////////////////////////////////////////
    // stage bundles
    ////////////////////////////////////////
    typedef struct packed {
        logic            is_jal;
        logic            is_jalr;
        logic            is_branch;
        logic [2:0]      funct3;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [xlen-1:0] imm;
    } pre_dec_t;

    typedef struct packed {
        logic            valid;
        logic            mispredict;
        logic            taken;
        logic [xlen-1:0] branch_pc;
        logic [xlen-1:0] recover_pc;
    } resolve_t;

    typedef struct packed {
        logic            valid;
        logic [31:0]     instr;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] pc_plus4;
        logic            pred_taken;
    } fetch_out_t;

endpackage

/* verilog/mini_decode.sv */
`timescale 1ns/1ns

module mini_decode (
    input  fetch_pkg::instr_u   instr_i,
    output fetch_pkg::pre_dec_t dec_o
);
    import fetch_pkg::*;

    logic [6:0]      opcode;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_j;
    logic [xlen-1:0] imm_i;

    // opcode sits in the same place in every format
    assign opcode = instr_i.b.opcode;

    // branch offset, bit 0 implied zero
    assign imm_b = {{20{instr_i.b.imm12}},
                    instr_i.b.imm11,
                    instr_i.b.imm10_5,
                    instr_i.b.imm4_1,
                    1'b0};

    // jal offset from the J view
    assign imm_j = {{12{instr_i.j.imm20}},
                    instr_i.j.imm19_12,
                    instr_i.j.imm11,
                    instr_i.j.imm10_1,
                    1'b0};

    // jalr offset is bits 31:20, which overlay imm12/imm10_5/rs2
    assign imm_i = {{20{instr_i.b.imm12}},
                    instr_i.b.imm12,
                    instr_i.b.imm10_5,
                    instr_i.b.rs2};

    always_comb begin
        dec_o        = '0;
        dec_o.funct3 = instr_i.b.funct3;
        dec_o.rs1    = instr_i.b.rs1;
        dec_o.rs2    = instr_i.b.rs2;
        case (opcode)
            op_jal: begin
                dec_o.is_jal = 1'b1;
                dec_o.imm    = imm_j;
            end
            op_jalr: begin
                dec_o.is_jalr = 1'b1;
                dec_o.imm     = imm_i;
            end
            op_branch: begin
                dec_o.is_branch = 1'b1;
                dec_o.imm       = imm_b;
            end
            default: dec_o.imm = '0;
        endcase
    end

endmodule

/* verilog/branch_compare.sv */
`timescale 1ns/1ns

module branch_compare (
    input  logic [fetch_pkg::xlen-1:0] a_i,
    input  logic [fetch_pkg::xlen-1:0] b_i,
    input  logic [2:0]                 funct3_i,
    output logic                       taken_o
);
    import fetch_pkg::*;

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (a_i == b_i);
    assign lt_s = ($signed(a_i) < $signed(b_i));
    assign lt_u = (a_i < b_i);

    // bne/bge/bgeu are the inverted forms
    always_comb begin
        case (funct3_i)
            f3_beq:  taken_o = eq;
            f3_bne:  taken_o = !eq;
            f3_blt:  taken_o = lt_s;
            f3_bge:  taken_o = !lt_s;
            f3_bltu: taken_o = lt_u;
            f3_bgeu: taken_o = !lt_u;
            default: taken_o = 1'b0;
        endcase
    end

endmodule

/* verilog/branch_predictor.sv */
`timescale 1ns/1ns

module branch_predictor (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       stall_i,
    input  logic [fetch_pkg::xlen-1:0] pc_i,
    output logic                       pred_taken_o,
    input  logic                       early_valid_i,
    input  logic                       early_taken_i,
    input  fetch_pkg::resolve_t        resolve_i
);
    import fetch_pkg::*;

    logic [1:0]                bht [bht_entries];
    logic [bht_index_bits-1:0] pred_idx;
    logic [bht_index_bits-1:0] res_idx;
    logic                      early_we;

    // saturating two-bit counter step
    function automatic logic [1:0] next_count(input logic [1:0] cnt, input logic taken);
        logic [1:0] res;
        res = cnt;
        if (taken && cnt != 2'b11) begin
            res = cnt + 2'd1;
        end else if (!taken && cnt != 2'b00) begin
            res = cnt - 2'd1;
        end
        return res;
    endfunction

    ////////////////////////////////////////
    // lookup
    ////////////////////////////////////////
    // word address bits 5:2
    assign pred_idx     = pc_i[bht_index_bits+1:2];
    assign res_idx      = resolve_i.branch_pc[bht_index_bits+1:2];
    assign pred_taken_o = bht[pred_idx][1];

    // early training frozen under stall
    assign early_we = early_valid_i && !stall_i;

    ////////////////////////////////////////
    // training
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst_i) begin
            // weakly not-taken
            for (int i = 0; i < bht_entries; i++) begin
                bht[i] <= 2'b01;
            end
        end else begin
            if (early_we) begin
                bht[pred_idx] <= next_count(bht[pred_idx], early_taken_i);
            end
            // later write wins when both hit one entry
            if (resolve_i.valid) begin
                bht[res_idx] <= next_count(bht[res_idx], resolve_i.taken);
            end
        end
    end

endmodule

/* verilog/pc_gen.sv */
`timescale 1ns/1ns

module pc_gen (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       hold_i,
    input  fetch_pkg::pre_dec_t        dec_i,
    input  logic                       branch_taken_i,
    input  logic [fetch_pkg::xlen-1:0] rs1_data_i,
    input  fetch_pkg::resolve_t        resolve_i,
    output logic [fetch_pkg::xlen-1:0] pc_o,
    output logic [fetch_pkg::xlen-1:0] pc_plus4_o
);
    import fetch_pkg::*;

    logic [xlen-1:0] pc_q;
    logic [xlen-1:0] pc_next;
    logic [xlen-1:0] add_base;
    logic [xlen-1:0] target_sum;
    logic [xlen-1:0] target;
    logic            redirect;
    logic            recover;

    ////////////////////////////////////////
    // adders
    ////////////////////////////////////////
    assign pc_plus4_o = pc_q + 32'd4;

    // jalr adds to rs1, everything else to the pc
    assign add_base   = dec_i.is_jalr ? rs1_data_i : pc_q;
    assign target_sum = add_base + dec_i.imm;
    assign target     = dec_i.is_jalr ? {target_sum[xlen-1:1], 1'b0} : target_sum;

    ////////////////////////////////////////
    // next pc
    ////////////////////////////////////////
    assign recover  = resolve_i.valid && resolve_i.mispredict;
    assign redirect = dec_i.is_jal || dec_i.is_jalr || (dec_i.is_branch && branch_taken_i);

    // recovery beats any stall
    always_comb begin
        if (recover) begin
            pc_next = resolve_i.recover_pc;
        end else if (hold_i) begin
            pc_next = pc_q;
        end else if (redirect) begin
            pc_next = target;
        end else begin
            pc_next = pc_plus4_o;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= reset_pc;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

endmodule

/* verilog/if_stage.sv */
`timescale 1ns/1ns

module if_stage (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic [31:0]                instr_i,
    input  logic                       stall_i,
    input  logic [fetch_pkg::xlen-1:0] rs1_data_i,
    input  logic [fetch_pkg::xlen-1:0] rs2_data_i,
    input  logic                       rs1_ready_i,
    input  logic                       rs2_ready_i,
    input  fetch_pkg::resolve_t        resolve_i,
    output logic [fetch_pkg::xlen-1:0] rom_addr_o,
    output logic [4:0]                 rs1_addr_o,
    output logic [4:0]                 rs2_addr_o,
    output fetch_pkg::fetch_out_t      fetch_o
);
    import fetch_pkg::*;

    pre_dec_t        dec;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_plus4;
    logic            cmp_taken;
    logic            pred_taken;
    logic            early;
    logic            branch_taken;
    logic            self_stall;
    logic            hold;

    mini_decode i_mini_decode (
        .instr_i (instr_i),
        .dec_o   (dec)
    );

    ////////////////////////////////////////
    // branch decision
    ////////////////////////////////////////
    branch_compare i_branch_compare (
        .a_i      (rs1_data_i),
        .b_i      (rs2_data_i),
        .funct3_i (dec.funct3),
        .taken_o  (cmp_taken)
    );

    // both operands ready means resolve here
    assign early        = dec.is_branch && rs1_ready_i && rs2_ready_i;
    assign branch_taken = early ? cmp_taken : pred_taken;

    // jalr waits for its base
    assign self_stall = dec.is_jalr && !rs1_ready_i;
    assign hold       = stall_i || self_stall;

    branch_predictor i_branch_predictor (
        .clk           (clk),
        .rst_i         (rst_i),
        .stall_i       (hold),
        .pc_i          (pc),
        .pred_taken_o  (pred_taken),
        .early_valid_i (early),
        .early_taken_i (cmp_taken),
        .resolve_i     (resolve_i)
    );

    ////////////////////////////////////////
    // pc and outputs
    ////////////////////////////////////////
    pc_gen i_pc_gen (
        .clk            (clk),
        .rst_i          (rst_i),
        .hold_i         (hold),
        .dec_i          (dec),
        .branch_taken_i (branch_taken),
        .rs1_data_i     (rs1_data_i),
        .resolve_i      (resolve_i),
        .pc_o           (pc),
        .pc_plus4_o     (pc_plus4)
    );

    assign rom_addr_o = pc;
    assign rs1_addr_o = dec.rs1;
    assign rs2_addr_o = dec.rs2;

    assign fetch_o.valid      = !self_stall;
    assign fetch_o.instr      = self_stall ? nop_instr : instr_i;
    assign fetch_o.pc         = pc;
    assign fetch_o.pc_plus4   = pc_plus4;
    // only predicted branches carry a prediction
    assign fetch_o.pred_taken = dec.is_branch && !early && branch_taken;

endmodule

/* tb/if_stage_tb.sv */
`timescale 1ns/1ns

module if_stage_tb;
    import fetch_pkg::*;

    logic        clk;
    logic        rst_i;
    logic [31:0] instr_i;
    logic        stall_i;
    logic [31:0] rs1_data_i;
    logic [31:0] rs2_data_i;
    logic        rs1_ready_i;
    logic        rs2_ready_i;
    resolve_t    resolve_i;
    logic [31:0] rom_addr_o;
    logic [4:0]  rs1_addr_o;
    logic [4:0]  rs2_addr_o;
    fetch_out_t  fetch_o;

    logic [31:0] rom [256];
    logic [31:0] rand_state;
    string       cur_test;
    int          errors;
    int          checks;
    int          tests;

    if_stage i_if_stage (
        .clk         (clk),
        .rst_i       (rst_i),
        .instr_i     (instr_i),
        .stall_i     (stall_i),
        .rs1_data_i  (rs1_data_i),
        .rs2_data_i  (rs2_data_i),
        .rs1_ready_i (rs1_ready_i),
        .rs2_ready_i (rs2_ready_i),
        .resolve_i   (resolve_i),
        .rom_addr_o  (rom_addr_o),
        .rs1_addr_o  (rs1_addr_o),
        .rs2_addr_o  (rs2_addr_o),
        .fetch_o     (fetch_o)
    );

    // single-cycle word-addressed ROM
    assign instr_i = rom[rom_addr_o[9:2]];

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////
    // encoders and reference rules
    ////////////////////////////////////////
    function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] jalr_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b1100111};
    endfunction

    function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    // addi x0,x0,idx so every word differs
    function automatic logic [31:0] filler_word(input logic [7:0] idx);
        return {4'd0, idx, 5'd0, 3'b000, 5'd0, 7'b0010011};
    endfunction

    function automatic logic branch_outcome(input logic [2:0] f3, input logic [31:0] a,
                                            input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////
    task automatic load_filler();
        for (int i = 0; i < 256; i++) begin
            rom[i[7:0]] = filler_word(i[7:0]);
        end
    endtask

    task automatic put_word(input logic [31:0] addr, input logic [31:0] word);
        rom[addr[9:2]] = word;
    endtask

    task automatic check_eq(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("[ERROR] %s %s: expected 0x%08h, actual 0x%08h",
                     cur_test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_i = 1'b1;
        repeat (16) @(negedge clk);
        rst_i = 1'b0;
    endtask

    task automatic wait_for_pc(input logic [31:0] pc, input int limit);
        int n;
        n = 0;
        while (rom_addr_o != pc && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (rom_addr_o != pc) begin
            $display("%s: timed out waiting for fetch address 0x%08h", cur_test, pc);
            errors++;
        end
    endtask

    // one-cycle report from a falling edge
    task automatic send_resolve(input logic mispredict, input logic taken,
                                input logic [31:0] branch_pc, input logic [31:0] recover_pc);
        resolve_i.valid      = 1'b1;
        resolve_i.mispredict = mispredict;
        resolve_i.taken      = taken;
        resolve_i.branch_pc  = branch_pc;
        resolve_i.recover_pc = recover_pc;
        @(negedge clk);
        resolve_i.valid = 1'b0;
    endtask

    task automatic report_test(input int e0);
        tests++;
        if (errors == e0) begin
            $display("%s: passed", cur_test);
        end else begin
            $display("%s: failed with %0d errors", cur_test, errors - e0);
        end
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////
    task automatic seq_fetch_and_stall();
        int e0;
        e0 = errors;
        cur_test = "seq_fetch_and_stall";
        load_filler();
        apply_reset();
        for (int i = 0; i < 5; i++) begin
            check_eq("pc", 32'(i * 4), rom_addr_o);
            check_eq("fetch pc", 32'(i * 4), fetch_o.pc);
            check_eq("valid", 32'd1, {31'd0, fetch_o.valid});
            @(negedge clk);
        end
        stall_i = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_eq("stalled pc", 32'd20, rom_addr_o);
            check_eq("stalled instr", filler_word(8'd5), fetch_o.instr);
        end
        stall_i = 1'b0;
        @(negedge clk);
        check_eq("pc after stall", 32'd24, rom_addr_o);
        report_test(e0);
    endtask

    task automatic jal_redirect();
        int e0;
        e0 = errors;
        cur_test = "jal_redirect";
        load_filler();
        put_word(32'h08, jal_word(5'd1, 21'h0_0040));
        // backward jump of 0x30
        put_word(32'h48, jal_word(5'd0, 21'h1f_ffd0));
        apply_reset();
        wait_for_pc(32'h08, 10);
        check_eq("pc_plus4", 32'h0c, fetch_o.pc_plus4);
        @(negedge clk);
        check_eq("forward target", 32'h48, rom_addr_o);
        @(negedge clk);
        check_eq("backward target", 32'h18, rom_addr_o);
        report_test(e0);
    endtask

    task automatic early_branches();
        logic [2:0]  kinds [6];
        logic [31:0] a;
        logic [31:0] b;
        logic        want;
        int          e0;
        kinds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        e0 = errors;
        cur_test = "early_branches";
        rs1_ready_i = 1'b1;
        rs2_ready_i = 1'b1;
        for (int k = 0; k < 6; k++) begin
            for (int t = 0; t < 3; t++) begin
                a = next_rand();
                b = (t == 0) ? a : next_rand();
                // opposite signs split signed from unsigned
                if (t == 2) begin
                    b[31] = ~a[31];
                end
                want = branch_outcome(kinds[k], a, b);
                load_filler();
                put_word(32'h10, branch_word(kinds[k], 5'd3, 5'd4, 13'h0020));
                rs1_data_i = a;
                rs2_data_i = b;
                apply_reset();
                wait_for_pc(32'h10, 20);
                check_eq("rs2 addr", 32'd4, {27'd0, rs2_addr_o});
                check_eq("pred_taken", 32'd0, {31'd0, fetch_o.pred_taken});
                @(negedge clk);
                check_eq("next pc", want ? 32'h30 : 32'h14, rom_addr_o);
            end
        end
        report_test(e0);
    endtask

    task automatic jalr_wait();
        int e0;
        e0 = errors;
        cur_test = "jalr_wait";
        load_filler();
        put_word(32'h08, jalr_word(5'd1, 5'd5, 12'h020));
        rs1_ready_i = 1'b0;
        rs2_ready_i = 1'b1;
        rs1_data_i  = 32'hdead_0000;
        apply_reset();
        wait_for_pc(32'h08, 10);
        check_eq("valid", 32'd0, {31'd0, fetch_o.valid});
        check_eq("instr", 32'h0000_0013, fetch_o.instr);
        check_eq("rs1 addr", 32'd5, {27'd0, rs1_addr_o});
        @(negedge clk);
        check_eq("held pc", 32'h08, rom_addr_o);
        rs1_ready_i = 1'b1;
        rs1_data_i  = 32'h0000_0101;
        @(negedge clk);
        check_eq("target", 32'h120, rom_addr_o);
        report_test(e0);
    endtask

    task automatic predictor_training();
        int e0;
        e0 = errors;
        cur_test = "predictor_training";
        load_filler();
        put_word(32'h10, branch_word(3'b000, 5'd6, 5'd7, 13'h0040));
        // loop back to the branch
        put_word(32'h18, jal_word(5'd0, 21'h1f_fff8));
        rs1_ready_i = 1'b1;
        rs2_ready_i = 1'b0;
        apply_reset();
        wait_for_pc(32'h10, 10);
        check_eq("untrained pred", 32'd0, {31'd0, fetch_o.pred_taken});
        @(negedge clk);
        check_eq("fall through", 32'h14, rom_addr_o);
        stall_i = 1'b1;
        send_resolve(1'b0, 1'b1, 32'h10, 32'h0);
        send_resolve(1'b0, 1'b1, 32'h10, 32'h0);
        check_eq("held pc", 32'h14, rom_addr_o);
        stall_i = 1'b0;
        wait_for_pc(32'h10, 10);
        check_eq("trained pred", 32'd1, {31'd0, fetch_o.pred_taken});
        @(negedge clk);
        check_eq("predicted target", 32'h50, rom_addr_o);
        rs2_ready_i = 1'b1;
        report_test(e0);
    endtask

    task automatic mispredict_recovery();
        int e0;
        e0 = errors;
        cur_test = "mispredict_recovery";
        load_filler();
        apply_reset();
        wait_for_pc(32'h0c, 10);
        stall_i = 1'b1;
        send_resolve(1'b1, 1'b1, 32'h08, 32'h84);
        check_eq("recover pc", 32'h84, rom_addr_o);
        @(negedge clk);
        check_eq("held recover pc", 32'h84, rom_addr_o);
        stall_i = 1'b0;
        @(negedge clk);
        check_eq("after recovery", 32'h88, rom_addr_o);
        report_test(e0);
    endtask

    initial begin
        rst_i       = 1'b1;
        stall_i     = 1'b0;
        rs1_data_i  = '0;
        rs2_data_i  = '0;
        rs1_ready_i = 1'b1;
        rs2_ready_i = 1'b1;
        resolve_i   = '0;
        rand_state  = 32'd65;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        load_filler();

        seq_fetch_and_stall();
        jal_redirect();
        early_branches();
        jalr_wait();
        predictor_training();
        mispredict_recovery();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
verilog/fetch_pkg.sv
verilog/mini_decode.sv
verilog/branch_compare.sv
verilog/branch_predictor.sv
verilog/pc_gen.sv
verilog/if_stage.sv
tb/if_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the fetch stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module if_stage_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vif_stage_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "ALL CHECKS PASSED"; then
    exit 0
fi
echo "pass message not found"
exit 1
